// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_job_farm
LOG       ?= sim.log
LANES     ?= 4
OBJ_DIR   ?= obj_dir
FILELIST  := job_farm.f

VFLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) -GLANE_COUNT=$(LANES)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG LANES OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: job_farm.f
source/job_pkg.sv
source/farm_pkg.sv
source/job_if.sv
source/job_fifo_buf.sv
source/job_dispatcher.sv
source/job_lane.sv
source/result_collector.sv
source/job_farm.sv
tests/job_farm_checker.sv
tests/tb_job_farm.sv

// File: source/farm_pkg.sv
package farm_pkg;

    parameter int LANE_COUNT_DEF = 4;
    parameter int DEPTH_DEF      = 3;   // address bits, 8 entries per buffer

    // a single lane still needs a one bit index
    function automatic int lane_idx_w(input int lanes);
        return (lanes > 1) ? $clog2(lanes) : 1;
    endfunction

endpackage

// File: source/job_dispatcher.sv
module job_dispatcher #(
    parameter int LANE_COUNT = farm_pkg::LANE_COUNT_DEF
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          job_req,
    input  job_pkg::job_t job_in,
    output logic          job_ack,
    job_if.dispatcher     lanes [LANE_COUNT]
);
    import job_pkg::*;
    import farm_pkg::*;

    localparam int IDX_W = lane_idx_w(LANE_COUNT);

    typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_HOLD} state_t;

    state_t                state_q;
    job_t                  job_q;
    logic [IDX_W-1:0]      sel_q;
    logic [IDX_W-1:0]      best_idx;
    int unsigned           best_space;
    int unsigned           space_arr [LANE_COUNT];
    logic [LANE_COUNT-1:0] req_vec;
    logic [LANE_COUNT-1:0] ack_vec;

    for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
        assign space_arr[g]  = 32'(lanes[g].space);
        assign ack_vec[g]    = lanes[g].ack;
        assign req_vec[g]    = (state_q == ST_SEND) && (sel_q == IDX_W'(g));
        assign lanes[g].req  = req_vec[g];
        assign lanes[g].job  = job_q;

        // a lane only acks a job it was offered
        a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
            $rose(ack_vec[g]) |-> $past(req_vec[g]));
    end

    // strict compare keeps the lowest index on a tie and never picks zero space
    always_comb begin
        best_idx   = '0;
        best_space = 0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            if (space_arr[i] > best_space) begin
                best_idx   = IDX_W'(i);
                best_space = space_arr[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= ST_IDLE;
            sel_q   <= '0;
            job_ack <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (job_req && best_space != 0) begin  // all full means no ack
                        sel_q   <= best_idx;
                        state_q <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (ack_vec[sel_q]) begin
                        job_ack <= 1'b1;
                        state_q <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (!job_req && !ack_vec[sel_q]) begin
                        job_ack <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && job_req) begin
            job_q <= job_in;
        end
    end

endmodule

// File: source/job_farm.sv
module job_farm #(
    parameter int LANE_COUNT = farm_pkg::LANE_COUNT_DEF,
    parameter int DEPTH      = farm_pkg::DEPTH_DEF
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      job_req,
    input  logic [job_pkg::TAG_W-1:0] job_tag,
    input  logic [job_pkg::CMD_W-1:0] job_cmd,
    input  logic [job_pkg::OP_W-1:0]  job_op,
    output logic                      job_ack,
    output logic                      res_req,
    output logic [job_pkg::TAG_W-1:0] res_tag,
    output logic                      res_err,
    output logic [job_pkg::OP_W-1:0]  res_value,
    input  logic                      res_ack
);
    import job_pkg::*;

    job_t job_in;

    assign job_in = '{tag: job_tag, cmd: job_cmd, operand: job_op};

    job_if #(.DEPTH(DEPTH)) job_link [LANE_COUNT] ();
    res_if                  res_link [LANE_COUNT] ();

    job_dispatcher #(.LANE_COUNT(LANE_COUNT)) dispatcher (
        .clk, .reset,
        .job_req, .job_in, .job_ack,
        .lanes(job_link)
    );

    for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
        job_lane #(.DEPTH(DEPTH)) lane (
            .clk, .reset,
            .jobs(job_link[g]),
            .results(res_link[g])
        );
    end

    result_collector #(.LANE_COUNT(LANE_COUNT)) collector (
        .clk, .reset,
        .lanes(res_link),
        .res_req, .res_tag, .res_err, .res_value, .res_ack
    );

endmodule

// File: source/job_fifo_buf.sv
module job_fifo_buf #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = farm_pkg::DEPTH_DEF
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           wr,
    input  logic           rd,
    input  payload_t       w_data,
    output payload_t       r_data,
    output logic           full,
    output logic           empty,
    output logic [DEPTH:0] space
);
    localparam int SLOTS = 2 ** DEPTH;
    localparam logic [DEPTH:0] SPACE_MAX = (DEPTH + 1)'(SLOTS);

    payload_t mem [SLOTS];

    logic [DEPTH-1:0] w_ptr;
    logic [DEPTH-1:0] w_ptr_next;
    logic [DEPTH-1:0] w_ptr_succ;
    logic [DEPTH-1:0] r_ptr;
    logic [DEPTH-1:0] r_ptr_next;
    logic [DEPTH-1:0] r_ptr_succ;
    logic [DEPTH-1:0] used;
    logic             full_q;
    logic             full_next;
    logic             empty_q;
    logic             empty_next;
    logic             wr_en;

    assign wr_en  = wr & ~full_q;
    assign r_data = mem[r_ptr];     // read data straight from the read pointer
    assign used   = w_ptr - r_ptr;  // wraps, valid whenever not full
    assign full   = full_q;
    assign empty  = empty_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[w_ptr] <= w_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ptr   <= '0;
            r_ptr   <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
            space   <= SPACE_MAX;
        end else begin
            w_ptr   <= w_ptr_next;
            r_ptr   <= r_ptr_next;
            full_q  <= full_next;
            empty_q <= empty_next;
            space   <= full_q ? '0 : SPACE_MAX - {1'b0, used};  // one cycle behind the pointers
        end
    end

    // **************************************************
    // pointer successors and flags
    // **************************************************
    always_comb begin
        w_ptr_succ = w_ptr + 1'b1;
        r_ptr_succ = r_ptr + 1'b1;
        w_ptr_next = w_ptr;
        r_ptr_next = r_ptr;
        full_next  = full_q;
        empty_next = empty_q;
        case ({wr, rd})
            2'b01: begin
                if (!empty_q) begin
                    r_ptr_next = r_ptr_succ;
                    full_next  = 1'b0;
                    empty_next = (r_ptr_succ == w_ptr);
                end
            end
            2'b10: begin
                if (!full_q) begin
                    w_ptr_next = w_ptr_succ;
                    empty_next = 1'b0;
                    full_next  = (w_ptr_succ == r_ptr);
                end
            end
            2'b11: begin
                if (empty_q) begin          // nothing to read, write only
                    w_ptr_next = w_ptr_succ;
                    empty_next = 1'b0;
                end else if (full_q) begin  // no room, read only
                    r_ptr_next = r_ptr_succ;
                    full_next  = 1'b0;
                end else begin
                    w_ptr_next = w_ptr_succ;
                    r_ptr_next = r_ptr_succ;
                end
            end
            default: ;
        endcase
    end

    a_no_read_empty: assert property (@(posedge clk) disable iff (reset) !(rd && empty_q));
    a_no_write_full: assert property (@(posedge clk) disable iff (reset) !(wr && full_q));

endmodule

// File: source/job_if.sv
interface job_if #(
    parameter int DEPTH = farm_pkg::DEPTH_DEF
);
    import job_pkg::*;

    logic           req;
    logic           ack;
    job_t           job;
    logic [DEPTH:0] space;    // free entries in the lane job queue

    modport dispatcher (output req, output job, input ack, input space);
    modport lane (input req, input job, output ack, output space);
endinterface

interface res_if;
    import job_pkg::*;

    logic    req;
    logic    ack;
    result_t result;

    modport lane (output req, output result, input ack);
    modport collector (input req, input result, output ack);
endinterface

// File: source/job_lane.sv
module job_lane #(
    parameter int DEPTH = farm_pkg::DEPTH_DEF
) (
    input logic    clk,
    input logic    reset,
    job_if.lane    jobs,
    res_if.lane    results
);
    import job_pkg::*;

    job_t              job_rd;
    result_t           exec_res;
    logic              job_full;
    logic              job_empty;
    logic              job_wr;
    logic              res_full;
    logic              res_empty;
    logic              res_rd;
    logic              exec;
    logic              ack_q;
    logic              req_q;
    logic [HALF_W-1:0] hi;
    logic [HALF_W-1:0] lo;

    assign job_wr      = jobs.req && !ack_q && !job_full;
    assign jobs.ack    = ack_q;
    assign exec        = !job_empty && !res_full;  // one job per cycle
    assign res_rd      = req_q && results.ack;     // pop as req falls
    assign results.req = req_q;

    job_fifo_buf #(.payload_t(job_t), .DEPTH(DEPTH)) job_q (
        .clk, .reset,
        .wr(job_wr), .rd(exec),
        .w_data(jobs.job), .r_data(job_rd),
        .full(job_full), .empty(job_empty), .space(jobs.space)
    );

    job_fifo_buf #(.payload_t(result_t), .DEPTH(DEPTH)) res_q (
        .clk, .reset,
        .wr(exec), .rd(res_rd),
        .w_data(exec_res), .r_data(results.result),
        .full(res_full), .empty(res_empty), .space()
    );

    // **************************************************
    // executor
    // **************************************************
    assign hi = job_rd.operand[OP_W-1:HALF_W];
    assign lo = job_rd.operand[HALF_W-1:0];

    always_comb begin
        exec_res.tag = job_rd.tag;
        exec_res.err = 1'b0;
        case (job_rd.cmd)
            CMD_ADD:  exec_res.value = OP_W'({1'b0, hi} + {1'b0, lo});  // carry kept in bit 32
            CMD_XOR:  exec_res.value = OP_W'(hi ^ lo);
            CMD_SWAP: exec_res.value = {lo, hi};
            CMD_PASS: exec_res.value = job_rd.operand;
            default: begin
                exec_res.err   = 1'b1;
                exec_res.value = ERR_VALUE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
            req_q <= 1'b0;
        end else begin
            if (job_wr) begin
                ack_q <= 1'b1;
            end else if (!jobs.req) begin
                ack_q <= 1'b0;
            end
            if (req_q && results.ack) begin
                req_q <= 1'b0;
            end else if (!req_q && !results.ack && !res_empty) begin
                req_q <= 1'b1;  // wait for ack low before the next offer
            end
        end
    end

endmodule

// File: source/job_pkg.sv
package job_pkg;

    parameter int TAG_W  = 8;
    parameter int CMD_W  = 6;
    parameter int OP_W   = 64;
    parameter int HALF_W = OP_W / 2;

    typedef enum logic [CMD_W-1:0] {
        CMD_PASS = 6'h00,
        CMD_ADD  = 6'h01,
        CMD_XOR  = 6'h02,
        CMD_SWAP = 6'h03
    } cmd_e;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [CMD_W-1:0] cmd;      // raw code, may hold an invalid value
        logic [OP_W-1:0]  operand;
    } job_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             err;
        logic [OP_W-1:0]  value;
    } result_t;

    parameter logic [OP_W-1:0] ERR_VALUE = '1;  // value returned for unknown codes

endpackage

// File: source/result_collector.sv
module result_collector #(
    parameter int LANE_COUNT = farm_pkg::LANE_COUNT_DEF
) (
    input  logic                     clk,
    input  logic                     reset,
    res_if.collector                 lanes [LANE_COUNT],
    output logic                     res_req,
    output logic [job_pkg::TAG_W-1:0] res_tag,
    output logic                     res_err,
    output logic [job_pkg::OP_W-1:0] res_value,
    input  logic                     res_ack
);
    import job_pkg::*;
    import farm_pkg::*;

    localparam int IDX_W = lane_idx_w(LANE_COUNT);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_REQ, ST_ACK} state_t;

    state_t                state_q;
    logic [IDX_W-1:0]      last_q;     // grant pointer
    logic [IDX_W-1:0]      next_idx;
    logic                  found;
    int                    cand;
    result_t               out_q;
    result_t               res_arr [LANE_COUNT];
    logic [LANE_COUNT-1:0] req_vec;

    for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
        assign req_vec[g]   = lanes[g].req;
        assign res_arr[g]   = lanes[g].result;
        assign lanes[g].ack = (state_q == ST_ACK) && (last_q == IDX_W'(g));

        // lane result held steady until acked
        a_lane_stable: assert property (@(posedge clk) disable iff (reset)
            req_vec[g] && !lanes[g].ack |=> $stable(res_arr[g]));
    end

    assign res_tag   = out_q.tag;
    assign res_err   = out_q.err;
    assign res_value = out_q.value;

    // descending scan so the nearest lane after the last grant wins
    always_comb begin
        next_idx = last_q;
        found    = 1'b0;
        cand     = 0;
        for (int k = LANE_COUNT; k >= 1; k--) begin
            cand = (int'(last_q) + k) % LANE_COUNT;
            if (req_vec[cand]) begin
                next_idx = IDX_W'(cand);
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= ST_IDLE;
            last_q  <= IDX_W'(LANE_COUNT - 1);  // lane 0 first
            res_req <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (found) begin
                        last_q  <= next_idx;
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    res_req <= 1'b1;
                    state_q <= ST_REQ;
                end
                ST_REQ: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state_q <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!req_vec[last_q] && !res_ack) begin  // both links back to idle
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && found) begin
            out_q <= res_arr[next_idx];
        end
    end

endmodule

// File: tests/job_farm_checker.sv
module job_farm_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      hold,       // keeps res_ack off
    input  logic                      exp_valid,
    input  logic [job_pkg::TAG_W-1:0] exp_tag,
    input  logic [job_pkg::CMD_W-1:0] exp_cmd,
    input  logic                      exp_err,
    input  logic [job_pkg::OP_W-1:0]  exp_value,
    input  logic                      report,     // list tags that never came back
    input  logic                      res_req,
    input  logic [job_pkg::TAG_W-1:0] res_tag,
    input  logic                      res_err,
    input  logic [job_pkg::OP_W-1:0]  res_value,
    output logic                      res_ack,
    output int                        returned,
    output int                        errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import job_pkg::*;

    localparam int ACK_TIMEOUT = 100;

    logic [31:0]      lfsr;
    logic             known [256];
    logic             seen [256];
    logic [CMD_W-1:0] cmd_a [256];
    logic             err_a [256];
    logic [OP_W-1:0]  val_a [256];

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
    endfunction

    function automatic string cmd_name(input logic [CMD_W-1:0] cmd);
        case (cmd)
            CMD_ADD:  return "add";
            CMD_XOR:  return "xor";
            CMD_SWAP: return "swap";
            CMD_PASS: return "pass";
            default:  return "invalid";
        endcase
    endfunction

    // three bits, one step each, so 0 to 7 cycles
    task automatic take_delay(output int cycles);
        cycles = 0;
        for (int b = 0; b < 3; b++) begin
            cycles = (cycles << 1) | int'(lfsr[0]);
            lfsr   = lfsr_step(lfsr);
        end
    endtask

    task automatic check_result();
        string name;
        name = $sformatf("%s_%02h", cmd_name(cmd_a[res_tag]), res_tag);
        if (!known[res_tag]) begin
            $display("result with unknown tag %02h arrived", res_tag);
            errors++;
        end else if (seen[res_tag]) begin
            $display("tag %02h came back more than once", res_tag);
            errors++;
        end else begin
            seen[res_tag] = 1'b1;
            returned++;
            if (res_err !== err_a[res_tag] || res_value !== val_a[res_tag]) begin
                $display("** Error %s: expected err=%0b value=%016h, actual err=%0b value=%016h",
                         name, err_a[res_tag], val_a[res_tag], res_err, res_value);
                errors++;
            end else begin
                $display("PASS %s err=%0b value=%016h", name, res_err, res_value);
            end
        end
    endtask

    // **************************************************
    // expectations from the stimulus side
    // **************************************************
    always @(posedge clk) begin
        if (exp_valid) begin
            if (known[exp_tag]) begin
                $display("tag %02h was sent twice", exp_tag);
                errors++;
            end
            known[exp_tag] = 1'b1;
            cmd_a[exp_tag] = exp_cmd;
            err_a[exp_tag] = exp_err;
            val_a[exp_tag] = exp_value;
        end
    end

    always @(posedge report) begin
        for (int t = 0; t < 256; t++) begin
            if (known[t] && !seen[t]) begin
                $display("tag %02h never came back", t);
                errors++;
            end
        end
    end

    // **************************************************
    // result port handshake
    // **************************************************
    initial begin
        int delay;
        int cnt;
        res_ack  = 1'b0;
        returned = 0;
        errors   = 0;
        lfsr     = 32'h0e49f35f;
        for (int t = 0; t < 256; t++) begin
            known[t] = 1'b0;
            seen[t]  = 1'b0;
        end
        forever begin
            @(posedge clk);
            #1;
            if (!reset && res_req && !res_ack && !hold) begin
                check_result();
                take_delay(delay);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                res_ack = 1'b1;
                cnt = 0;
                while (res_req && cnt < ACK_TIMEOUT) begin
                    @(posedge clk);
                    #1;
                    cnt++;
                end
                if (res_req) begin
                    $display("timeout: res_req stayed high after res_ack");
                    errors++;
                end
                res_ack = 1'b0;
            end
        end
    end

endmodule

// File: tests/job_farm_stim.txt
# columns in hex: tag cmd operand expected err
# cmd 00 pass, 01 add, 02 xor, 03 swap, anything else is invalid
00 01 0000000100000002 0000000000000003 0
01 01 ffffffff00000001 0000000100000000 0
02 01 123456789abcdef0 00000000acf13568 0
03 02 ffff00000f0f0f0f 00000000f0f00f0f 0
04 02 deadbeefdeadbeef 0000000000000000 0
05 03 0123456789abcdef 89abcdef01234567 0
06 03 00000000ffffffff ffffffff00000000 0
07 00 0123456789abcdef 0123456789abcdef 0
08 00 fedcba9876543210 fedcba9876543210 0
09 3f 0000000000000001 ffffffffffffffff 1
0a 04 1111111122222222 ffffffffffffffff 1
0b 01 8000000080000000 0000000100000000 0
0c 02 a5a5a5a55a5a5a5a 00000000ffffffff 0
0d 20 0000000000000000 ffffffffffffffff 1

// File: tests/tb_job_farm.sv
module tb_job_farm;
    timeunit 1ns;
    timeprecision 100ps;
    import job_pkg::*;

    parameter int LANE_COUNT = farm_pkg::LANE_COUNT_DEF;

    localparam int    TIMEOUT_CYCLES = 400;
    localparam int    DRAIN_CYCLES   = 5000;
    localparam int    STALL_CYCLES   = 40;   // job_ack wait that counts as back-pressure
    localparam int    MAX_JOBS       = 32;
    localparam int    BURST_JOBS     = 2 * LANE_COUNT * (2 ** farm_pkg::DEPTH_DEF) + 16;
    localparam string STIM_FILE      = "tests/job_farm_stim.txt";

    logic             clk;
    logic             reset;
    logic             job_req;
    logic [TAG_W-1:0] job_tag;
    logic [CMD_W-1:0] job_cmd;
    logic [OP_W-1:0]  job_op;
    logic             job_ack;
    logic             res_req;
    logic [TAG_W-1:0] res_tag;
    logic             res_err;
    logic [OP_W-1:0]  res_value;
    logic             res_ack;
    logic             hold;
    logic             report;
    logic             exp_valid;
    logic [TAG_W-1:0] exp_tag;
    logic [CMD_W-1:0] exp_cmd;
    logic             exp_err;
    logic [OP_W-1:0]  exp_value;
    int               returned;
    int               chk_errors;
    int               tb_errors;
    int               sent;
    int               n_jobs;
    bit               stalled;
    bit               aborted;
    logic [TAG_W-1:0] s_tag [MAX_JOBS];
    logic [CMD_W-1:0] s_cmd [MAX_JOBS];
    logic [OP_W-1:0]  s_op [MAX_JOBS];
    logic [OP_W-1:0]  s_exp [MAX_JOBS];
    logic             s_err [MAX_JOBS];

    job_farm #(.LANE_COUNT(LANE_COUNT), .DEPTH(farm_pkg::DEPTH_DEF)) dut (.*);

    job_farm_checker chk (.*, .errors(chk_errors));

    always #5 clk = ~clk;

    task automatic read_stim();
        int          fd;
        string       line;
        logic [31:0] tag;
        logic [31:0] cmd;
        logic [31:0] err;
        logic [63:0] op;
        logic [63:0] exp;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", STIM_FILE);
            tb_errors++;
            return;
        end
        while (!$feof(fd) && n_jobs < MAX_JOBS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h %h", tag, cmd, op, exp, err) == 5) begin
                s_tag[n_jobs] = tag[TAG_W-1:0];
                s_cmd[n_jobs] = cmd[CMD_W-1:0];
                s_op[n_jobs]  = op;
                s_exp[n_jobs] = exp;
                s_err[n_jobs] = err[0];
                n_jobs++;
            end
        end
        $fclose(fd);
    endtask

    // full four-phase transfer of stim entry idx under the given tag
    task automatic send_job(input int idx, input logic [TAG_W-1:0] tag);
        int cnt;
        @(posedge clk);
        #1;
        job_tag   = tag;
        job_cmd   = s_cmd[idx];
        job_op    = s_op[idx];
        job_req   = 1'b1;
        exp_valid = 1'b1;   // checker takes it on the next edge
        exp_tag   = tag;
        exp_cmd   = s_cmd[idx];
        exp_err   = s_err[idx];
        exp_value = s_exp[idx];
        @(posedge clk);
        #1;
        exp_valid = 1'b0;
        cnt = 0;
        while (!job_ack && cnt < TIMEOUT_CYCLES) begin
            if (hold && cnt == STALL_CYCLES) begin
                stalled = 1'b1;
                hold    = 1'b0;   // farm is full, let results drain
            end
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!job_ack) begin
            $display("timeout: job tag %02h was never acknowledged", tag);
            tb_errors++;
            aborted = 1'b1;
            return;
        end
        job_req = 1'b0;
        cnt = 0;
        while (job_ack && cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (job_ack) begin
            $display("timeout: job_ack stayed high for tag %02h", tag);
            tb_errors++;
            aborted = 1'b1;
            return;
        end
        sent++;
    endtask

    task automatic wait_results();
        int cnt;
        cnt = 0;
        while (returned < sent && cnt < DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (returned < sent) begin
            $display("timeout: only %0d of %0d results came back", returned, sent);
            tb_errors++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        job_req   = 1'b0;
        job_tag   = '0;
        job_cmd   = '0;
        job_op    = '0;
        hold      = 1'b0;
        report    = 1'b0;
        exp_valid = 1'b0;
        exp_tag   = '0;
        exp_cmd   = '0;
        exp_err   = 1'b0;
        exp_value = '0;
        tb_errors = 0;
        sent      = 0;
        n_jobs    = 0;
        stalled   = 1'b0;
        aborted   = 1'b0;
        read_stim();
        if (n_jobs == 0) begin
            $display("no jobs found in %s", STIM_FILE);
            tb_errors++;
            aborted = 1'b1;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        if (job_ack !== 1'b0 || res_req !== 1'b0) begin
            $display("** Error reset_state: expected job_ack=0 res_req=0, actual job_ack=%b res_req=%b",
                     job_ack, res_req);
            tb_errors++;
        end else begin
            $display("PASS reset_state job_ack=0 res_req=0");
        end

        for (int i = 0; i < n_jobs && !aborted; i++) begin
            send_job(i, s_tag[i]);
        end
        wait_results();

        // **************************************************
        // burst past the farm capacity with res_ack held off
        // **************************************************
        hold = 1'b1;
        for (int k = 0; k < BURST_JOBS && !aborted; k++) begin
            send_job(k % n_jobs, TAG_W'(32 + k));
        end
        hold = 1'b0;
        if (!aborted && !stalled) begin
            $display("job_ack never stalled during the burst of %0d jobs", BURST_JOBS);
            tb_errors++;
        end else if (!aborted) begin
            $display("PASS back_pressure job_ack stalled with the farm full");
        end
        wait_results();
        report = 1'b1;
        @(posedge clk);
        #1;

        $display("%0d jobs sent, %0d results back, %0d errors",
                 sent, returned, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
